/* src/conv_out_pkg.sv */
package conv_out_pkg;

  // geometry of one accumulator beat as it leaves the conv engine.
  localparam int unsigned MEMBERS    = 6;
  localparam int unsigned UNITS      = 2;
  localparam int unsigned WORD_WIDTH = 16;
  localparam int unsigned WORD_BYTES = WORD_WIDTH / 8;
  localparam int unsigned USER_WIDTH = 8;

  // largest kernel width that the phase field of an output beat can label.
  localparam int unsigned KERNEL_W_CEIL = 8;
  localparam int unsigned PHASE_BITS    = $clog2(KERNEL_W_CEIL);

  // width of a kw_1 or phase value for a given maximum kernel width.
  function automatic int unsigned kw_bits(input int unsigned kernel_w_max);
    int unsigned bits;
    bits = (kernel_w_max > 1) ? $clog2(kernel_w_max) : 1;
    return bits;
  endfunction

  typedef logic [UNITS-1:0][WORD_WIDTH-1:0] member_data_t;
  typedef logic [UNITS*WORD_BYTES-1:0]      member_keep_t;

  // one word group per member, keep is per byte.
  typedef struct packed {
    member_data_t [MEMBERS-1:0] data;
    member_keep_t [MEMBERS-1:0] keep;
    logic [USER_WIDTH-1:0]      user;
    logic                       last;
  } in_beat_t;

  // same payload plus the replay phase it was issued on.
  typedef struct packed {
    member_data_t [MEMBERS-1:0] data;
    member_keep_t [MEMBERS-1:0] keep;
    logic [USER_WIDTH-1:0]      user;
    logic                       last;
    logic [PHASE_BITS-1:0]      phase;
  } out_beat_t;

endpackage

/* src/axis_slice.sv */
`timescale 1ns/1ps

module axis_slice #(
  parameter type payload_t = logic
) (
  input  logic     aclk,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic load;

  // the stage takes a new beat whenever it is empty or its content leaves
  // in the same cycle, so a steady stream passes with no bubble.
  assign in_ready = !out_valid || out_ready;
  assign load     = in_valid && in_ready;

  always_ff @(posedge aclk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid; // drops when the beat leaves and nothing follows.
    end
  end

  // payload only moves on a transfer, so it holds still under back-pressure.
  always_ff @(posedge aclk) begin
    if (load) begin
      out_data <= in_data;
    end
  end

endmodule

/* src/replay_ctrl.sv */
`timescale 1ns/1ps

module replay_ctrl #(
  parameter  int unsigned KERNEL_W_MAX = 7,
  localparam int unsigned KW_BITS      = conv_out_pkg::kw_bits(KERNEL_W_MAX)
) (
  input  logic               aclk,
  input  logic               reset,
  input  logic               hold_valid,
  output logic               hold_ready,
  input  logic [KW_BITS-1:0] kw_1,
  output logic [KW_BITS-1:0] phase,
  output logic               busy,
  output logic               out_valid,
  input  logic               out_ready
);
  import conv_out_pkg::*;

  typedef enum logic {
    S_IDLE,
    S_REPLAY
  } state_t;

  state_t             state;
  state_t             state_next;
  logic [KW_BITS-1:0] count;
  logic [KW_BITS-1:0] count_next;
  logic               last_phase;
  logic               out_xfer;

  if (KW_BITS > PHASE_BITS) begin : g_width_check
    $error("replay_ctrl: KERNEL_W_MAX %0d does not fit the phase field", KERNEL_W_MAX);
  end

  assign last_phase = (count == '0);
  assign out_xfer   = out_valid && out_ready;

  // kw_1 is taken in the idle cycle. busy already covers that cycle, so the
  // width cannot move under a beat that is held or replaying.
  always_comb begin
    state_next = state;
    count_next = count;
    case (state)
      S_IDLE: begin
        if (hold_valid) begin
          state_next = S_REPLAY;
          count_next = kw_1;
        end
      end
      S_REPLAY: begin
        if (out_xfer) begin
          if (last_phase) begin
            state_next = S_IDLE;
          end else begin
            count_next = count - 1'b1;
          end
        end
      end
      default: begin
        state_next = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      state <= S_IDLE;
      count <= '0;
    end else begin
      state <= state_next;
      count <= count_next;
    end
  end

  assign out_valid  = (state == S_REPLAY);
  assign busy       = hold_valid; // a held beat pins the width until it is released.
  assign phase      = count;
  assign hold_ready = out_xfer && last_phase; // held beat is freed on phase 0 only.

endmodule

/* src/member_mask_gen.sv */
`timescale 1ns/1ps

module member_mask_gen #(
  parameter  int unsigned KERNEL_W_MAX = 7,
  localparam int unsigned KW_BITS      = conv_out_pkg::kw_bits(KERNEL_W_MAX)
) (
  input  conv_out_pkg::in_beat_t  beat_in,
  input  logic [KW_BITS-1:0]      kw_1,
  input  logic [KW_BITS-1:0]      phase,
  output conv_out_pkg::out_beat_t beat_out
);
  import conv_out_pkg::*;

  // member index modulo kernel width, one column per allowed width.
  logic [KW_BITS-1:0] mod_lut [MEMBERS][KERNEL_W_MAX];
  logic [MEMBERS-1:0] member_mask;

  if (KW_BITS > PHASE_BITS) begin : g_width_check
    $error("member_mask_gen: KERNEL_W_MAX %0d does not fit the phase field", KERNEL_W_MAX);
  end

  for (genvar m = 0; m < MEMBERS; m++) begin : g_member
    for (genvar w = 0; w < KERNEL_W_MAX; w++) begin : g_width
      assign mod_lut[m][w] = KW_BITS'(m % (w + 1));
    end

    // a member belongs to the current phase when its column lands on it.
    assign member_mask[m] = (mod_lut[m][kw_1] == phase);

    assign beat_out.keep[m] = beat_in.keep[m] & {(UNITS*WORD_BYTES){member_mask[m]}};
  end

  assign beat_out.data  = beat_in.data;
  assign beat_out.user  = beat_in.user;
  assign beat_out.last  = beat_in.last && (phase == '0); // last closes the final phase.
  assign beat_out.phase = PHASE_BITS'(phase);

endmodule

/* src/kw_cfg_port.sv */
`timescale 1ns/1ps

module kw_cfg_port #(
  parameter  int unsigned KERNEL_W_MAX = 7,
  localparam int unsigned KW_BITS      = conv_out_pkg::kw_bits(KERNEL_W_MAX)
) (
  input  logic               aclk,
  input  logic               reset,
  input  logic               cfg_req,
  input  logic [KW_BITS-1:0] cfg_kw_1,
  output logic               cfg_ack,
  input  logic               busy,
  output logic [KW_BITS-1:0] kw_1
);
  import conv_out_pkg::*;

  localparam logic [KW_BITS-1:0] KW_1_TOP = KW_BITS'(KERNEL_W_MAX - 1);

  typedef enum logic {
    S_WAIT,
    S_ACK
  } state_t;

  state_t             state;
  logic [KW_BITS-1:0] kw_clamped;

  if (KW_BITS > PHASE_BITS) begin : g_width_check
    $error("kw_cfg_port: KERNEL_W_MAX %0d does not fit the phase field", KERNEL_W_MAX);
  end

  assign kw_clamped = (cfg_kw_1 > KW_1_TOP) ? KW_1_TOP : cfg_kw_1;

  // a request is held off while a beat is being replayed.
  // once acked, the port waits for req to fall before it drops ack.
  always_ff @(posedge aclk) begin
    if (reset) begin
      state <= S_WAIT;
      kw_1  <= '0; // width 1, plain pass-through.
    end else begin
      case (state)
        S_WAIT: begin
          if (cfg_req && !busy) begin
            kw_1  <= kw_clamped;
            state <= S_ACK;
          end
        end
        S_ACK: begin
          if (!cfg_req) begin
            state <= S_WAIT;
          end
        end
        default: begin
          state <= S_WAIT;
        end
      endcase
    end
  end

  assign cfg_ack = (state == S_ACK);

endmodule

/* src/conv_out_filter.sv */
`timescale 1ns/1ps

module conv_out_filter #(
  parameter  int unsigned KERNEL_W_MAX = 7,
  localparam int unsigned KW_BITS      = conv_out_pkg::kw_bits(KERNEL_W_MAX)
) (
  input  logic                    aclk,
  input  logic                    reset,

  input  logic                    s_valid,
  output logic                    s_ready,
  input  conv_out_pkg::in_beat_t  s_beat,

  output logic                    m_valid,
  input  logic                    m_ready,
  output conv_out_pkg::out_beat_t m_beat,

  input  logic                    cfg_req,
  input  logic [KW_BITS-1:0]      cfg_kw_1,
  output logic                    cfg_ack
);
  import conv_out_pkg::*;

  logic               hold_valid;
  logic               hold_ready;
  in_beat_t           hold_beat;
  logic [KW_BITS-1:0] phase;
  logic [KW_BITS-1:0] kw_1;
  logic               busy;
  logic               filt_valid;
  logic               filt_ready;
  out_beat_t          filt_beat;

  axis_slice #(
    .payload_t (in_beat_t)
  ) i_in_slice (
    .aclk      (aclk),
    .reset     (reset),
    .in_valid  (s_valid),
    .in_ready  (s_ready),
    .in_data   (s_beat),
    .out_valid (hold_valid),
    .out_ready (hold_ready),
    .out_data  (hold_beat)
  );

  replay_ctrl #(
    .KERNEL_W_MAX (KERNEL_W_MAX)
  ) i_replay_ctrl (
    .aclk       (aclk),
    .reset      (reset),
    .hold_valid (hold_valid),
    .hold_ready (hold_ready),
    .kw_1       (kw_1),
    .phase      (phase),
    .busy       (busy),
    .out_valid  (filt_valid),
    .out_ready  (filt_ready)
  );

  member_mask_gen #(
    .KERNEL_W_MAX (KERNEL_W_MAX)
  ) i_member_mask_gen (
    .beat_in  (hold_beat),
    .kw_1     (kw_1),
    .phase    (phase),
    .beat_out (filt_beat)
  );

  kw_cfg_port #(
    .KERNEL_W_MAX (KERNEL_W_MAX)
  ) i_kw_cfg_port (
    .aclk     (aclk),
    .reset    (reset),
    .cfg_req  (cfg_req),
    .cfg_kw_1 (cfg_kw_1),
    .cfg_ack  (cfg_ack),
    .busy     (busy),
    .kw_1     (kw_1)
  );

  // the masked beat is registered once more before it leaves.
  axis_slice #(
    .payload_t (out_beat_t)
  ) i_out_slice (
    .aclk      (aclk),
    .reset     (reset),
    .in_valid  (filt_valid),
    .in_ready  (filt_ready),
    .in_data   (filt_beat),
    .out_valid (m_valid),
    .out_ready (m_ready),
    .out_data  (m_beat)
  );

endmodule

/* bench/conv_out_filter_props.sv */
`timescale 1ns/1ps

module conv_out_filter_props (
  input logic                    aclk,
  input logic                    reset,
  input logic                    m_valid,
  input logic                    m_ready,
  input conv_out_pkg::out_beat_t m_beat,
  input logic                    cfg_req,
  input logic                    cfg_ack
);

  // a stalled output beat stays put until the sink takes it.
  m_hold: assert property (@(posedge aclk) disable iff (reset)
    m_valid && !m_ready |=> m_valid && $stable(m_beat))
    else $error("m_beat changed or m_valid dropped while m_ready was low");

  // ack may only rise on a request and only fall once the request is gone.
  ack_rise: assert property (@(posedge aclk) disable iff (reset)
    !cfg_req && !cfg_ack |=> !cfg_ack)
    else $error("cfg_ack rose without cfg_req");

  ack_fall: assert property (@(posedge aclk) disable iff (reset)
    cfg_req && cfg_ack |=> cfg_ack)
    else $error("cfg_ack fell while cfg_req was still high");

  reset_state: assert property (@(posedge aclk)
    reset |=> !cfg_ack && !m_valid)
    else $error("cfg_ack or m_valid high one cycle after reset");

endmodule

bind conv_out_filter conv_out_filter_props i_props (
  .aclk    (aclk),
  .reset   (reset),
  .m_valid (m_valid),
  .m_ready (m_ready),
  .m_beat  (m_beat),
  .cfg_req (cfg_req),
  .cfg_ack (cfg_ack)
);

/* bench/conv_out_filter_tb.sv */
`timescale 1ns/1ps

module conv_out_filter_tb;
  import conv_out_pkg::*;

  localparam int unsigned KERNEL_W_MAX = 7;
  localparam int unsigned KW_BITS      = kw_bits(KERNEL_W_MAX);
  localparam int unsigned CMP_BITS     = MEMBERS * UNITS * WORD_WIDTH;
  localparam int          WAIT_LIMIT   = 1000;
  localparam int          DRAIN_LIMIT  = 4000;

  typedef logic [CMP_BITS-1:0] cmp_t;

  logic               aclk = 1'b0;
  logic               reset;
  logic               s_valid;
  logic               s_ready;
  in_beat_t           s_beat;
  logic               m_valid;
  logic               m_ready = 1'b0;
  out_beat_t          m_beat;
  logic               cfg_req;
  logic [KW_BITS-1:0] cfg_kw_1;
  logic               cfg_ack;

  logic [31:0]   lcg_state = 32'd66;
  logic [31:0]   ready_bits;
  logic          rand_ready;
  logic          ack_seen;
  int unsigned   kw_model;
  int            checks;
  int            errors;
  int            checks_mark;
  int            errors_mark;
  out_beat_t     expected_q[$];

  conv_out_filter #(
    .KERNEL_W_MAX (KERNEL_W_MAX)
  ) i_conv_out_filter (
    .aclk     (aclk),
    .reset    (reset),
    .s_valid  (s_valid),
    .s_ready  (s_ready),
    .s_beat   (s_beat),
    .m_valid  (m_valid),
    .m_ready  (m_ready),
    .m_beat   (m_beat),
    .cfg_req  (cfg_req),
    .cfg_kw_1 (cfg_kw_1),
    .cfg_ack  (cfg_ack)
  );

  always #5 aclk = ~aclk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic in_beat_t random_beat();
    in_beat_t    b;
    logic [31:0] r;
    for (int m = 0; m < MEMBERS; m++) begin
      b.data[m] = member_data_t'(next_rand());
      r = next_rand();
      b.keep[m] = member_keep_t'(r >> 20);
    end
    r = next_rand();
    b.user = USER_WIDTH'(r >> 16);
    b.last = r[29];
    return b;
  endfunction

  // a width request above the top is taken as the widest kernel.
  function automatic int unsigned clamp_kw(input int unsigned value);
    return (value > KERNEL_W_MAX - 1) ? KERNEL_W_MAX - 1 : value;
  endfunction

  // one input beat becomes kw + 1 outputs, phase counting down to zero.
  task automatic push_expected(input in_beat_t b, input int unsigned kw);
    out_beat_t e;
    for (int p = int'(kw); p >= 0; p--) begin
      e.data  = b.data;
      e.user  = b.user;
      e.last  = b.last && (p == 0);
      e.phase = PHASE_BITS'(p);
      for (int m = 0; m < MEMBERS; m++) begin
        e.keep[m] = ((m % (int'(kw) + 1)) == p) ? b.keep[m] : '0;
      end
      expected_q.push_back(e);
    end
  endtask

  task automatic compare_field(input string name, input cmp_t got, input cmp_t exp);
    checks++;
    assert (got == exp) else begin
      $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_output(input out_beat_t got);
    out_beat_t e;
    if (expected_q.size() == 0) begin
      $display("at %0t an output beat arrived with no prediction left", $time);
      errors++;
    end else begin
      e = expected_q.pop_front();
      compare_field("m_beat.phase", cmp_t'(got.phase), cmp_t'(e.phase));
      compare_field("m_beat.data", cmp_t'(got.data), cmp_t'(e.data));
      compare_field("m_beat.keep", cmp_t'(got.keep), cmp_t'(e.keep));
      compare_field("m_beat.user", cmp_t'(got.user), cmp_t'(e.user));
      compare_field("m_beat.last", cmp_t'(got.last), cmp_t'(e.last));
    end
  endtask

  // handshakes are sampled half a cycle ahead of the edge that completes them.
  always @(negedge aclk) begin
    if (!reset) begin
      if (cfg_ack && !ack_seen) begin
        kw_model = clamp_kw(int'(cfg_kw_1));
      end
      ack_seen = cfg_ack;
      if (s_valid && s_ready) begin
        push_expected(s_beat, kw_model);
      end
      if (m_valid && m_ready) begin
        check_output(m_beat);
      end
    end
  end

  // the ready draw for the next edge is taken on the falling edge.
  always @(negedge aclk) begin
    if (rand_ready) begin
      ready_bits = next_rand();
    end
  end

  always @(posedge aclk) begin
    if (rand_ready) begin
      m_ready <= (ready_bits[31:30] != 2'b00); // ready about three cycles in four.
    end else begin
      m_ready <= !reset;
    end
  end

  task automatic end_on_timeout(input string reason);
    $display("timeout at %0t: %s", $time, reason);
    $display("Some tests failed");
    $finish;
  endtask

  task automatic send_beat(input in_beat_t b);
    int waited;
    waited = 0;
    s_valid <= 1'b1;
    s_beat  <= b;
    @(negedge aclk);
    while (!s_ready && waited < WAIT_LIMIT) begin
      waited++;
      @(negedge aclk);
    end
    if (!s_ready) end_on_timeout("s_ready stayed low while a beat was offered");
    @(posedge aclk);
    s_valid <= 1'b0;
  endtask

  task automatic configure(input logic [KW_BITS-1:0] value);
    int waited;
    waited = 0;
    cfg_kw_1 <= value;
    cfg_req  <= 1'b1;
    @(negedge aclk);
    while (!cfg_ack && waited < WAIT_LIMIT) begin
      waited++;
      @(negedge aclk);
    end
    if (!cfg_ack) end_on_timeout("cfg_ack never rose after cfg_req");
    @(posedge aclk);
    cfg_req <= 1'b0;
    waited = 0;
    @(negedge aclk);
    while (cfg_ack && waited < WAIT_LIMIT) begin
      waited++;
      @(negedge aclk);
    end
    if (cfg_ack) end_on_timeout("cfg_ack stayed high after cfg_req fell");
    @(posedge aclk);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (expected_q.size() != 0 && waited < DRAIN_LIMIT) begin
      waited++;
      @(negedge aclk);
    end
    if (expected_q.size() != 0) end_on_timeout("predicted output beats never came out");
    @(posedge aclk);
  endtask

  task automatic finish_test(input int num, input string name);
    $display("test %0d %s: %0d checks, %0d errors", num, name,
             checks - checks_mark, errors - errors_mark);
    checks_mark = checks;
    errors_mark = errors;
  endtask

  initial begin
    in_beat_t b;
    reset      = 1'b1;
    s_valid    = 1'b0;
    s_beat     = '0;
    cfg_req    = 1'b0;
    cfg_kw_1   = '0;
    rand_ready = 1'b0;
    ack_seen   = 1'b0;
    kw_model   = 0; // width 1 out of reset.
    checks     = 0;
    errors     = 0;
    checks_mark = 0;
    errors_mark = 0;
    repeat (5) @(posedge aclk);
    reset <= 1'b0;
    @(negedge aclk);
    compare_field("m_valid", cmp_t'(m_valid), '0);
    compare_field("cfg_ack", cmp_t'(cfg_ack), '0);
    compare_field("s_ready", cmp_t'(s_ready), cmp_t'(1'b1));
    @(posedge aclk);
    for (int i = 0; i < 6; i++) send_beat(random_beat());
    wait_drain();
    finish_test(1, "pass-through after reset");

    configure(KW_BITS'(7)); // one above the largest kw_1.
    for (int i = 0; i < 3; i++) send_beat(random_beat());
    wait_drain();
    finish_test(2, "configuration handshake and clamp");

    configure(KW_BITS'(2));
    for (int i = 0; i < 6; i++) send_beat(random_beat());
    wait_drain();
    finish_test(3, "three phase replay");

    for (int i = 0; i < 6; i++) begin
      b = random_beat();
      b.last = (i % 2 == 0);
      send_beat(b);
    end
    wait_drain();
    finish_test(4, "last on phase zero");

    rand_ready <= 1'b1;
    configure(KW_BITS'(3));
    for (int i = 0; i < 20; i++) send_beat(random_beat());
    wait_drain();
    finish_test(5, "random back-pressure");

    configure(KW_BITS'(1));
    for (int i = 0; i < 8; i++) send_beat(random_beat());
    @(posedge aclk); // request goes out while the last beat is still replaying.
    configure(KW_BITS'(4));
    for (int i = 0; i < 8; i++) send_beat(random_beat());
    wait_drain();
    finish_test(6, "width change while streaming");

    rand_ready <= 1'b0;
    repeat (10) @(posedge aclk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* conv_out_filter.f */
src/conv_out_pkg.sv
src/axis_slice.sv
src/replay_ctrl.sv
src/member_mask_gen.sv
src/kw_cfg_port.sv
src/conv_out_filter.sv
bench/conv_out_filter_props.sv
bench/conv_out_filter_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and decide from the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module conv_out_filter_tb -f conv_out_filter.f -o conv_out_filter_sim \
  && ./obj_dir/conv_out_filter_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -qx "All tests passed" sim.log || exit 1
exit 0
